// ==== design/uart_pkg.sv ====
package uart_pkg;

  // One byte on the serial line.
  typedef logic [7:0] uart_byte_t;

  typedef logic [31:0] uart_sum_t;  // Running byte sum, wraps modulo 2^32.

  // Fixed message, sent first byte first.
  localparam int msg_len = 13;
  typedef logic [3:0] msg_idx_t;    // Holds 0 to msg_len-1.

  // String literal packs 'H' into the top byte, newline into the bottom one.
  localparam logic [8*msg_len-1:0] msg_text = "Hello World!\n";

  localparam int tx_credits = 1;    // Byte slots in the transmitter.

  // Sender to transmitter request. Never refused, paced by credits.
  typedef struct packed {
    logic       valid;              // One cycle per byte handed over.
    uart_byte_t data;
  } tx_req_t;

  typedef enum logic [1:0] {
    hello_idle,                     // Waiting for a start pulse.
    hello_send,                     // Bytes left to hand over.
    hello_drain                     // Waiting for the last credit.
  } hello_state_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_t;

endpackage

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
  parameter int cycles_per_bit = 4          // Clocks per bit, 2 or more.
) (
  input  logic              clk,
  input  logic              rst_n,
  input  uart_pkg::tx_req_t i_req,          // Byte from the sender.
  output logic              o_credit,       // One credit back per frame.
  output logic              o_serial        // Line, idles high.
);
  import uart_pkg::*;

  localparam int cycle_bits = $clog2(cycles_per_bit);
  localparam logic [cycle_bits-1:0] cycle_max = cycle_bits'(cycles_per_bit - 1);

  tx_state_t             state;
  logic [cycle_bits-1:0] cycle;             // Countdown within the current bit.
  logic [2:0]            bit_idx;           // Data bit being sent.
  uart_byte_t            shreg;             // Holding slot, shifts out LSB first.
  logic                  bit_end;           // Last cycle of the current bit.

  assign bit_end  = cycle == '0;
  assign o_credit = (state == tx_stop) && bit_end;  // Slot is free from the next cycle.

  // Line level follows the state directly.
  always_comb begin
    case (state)
      tx_start: o_serial = 1'b0;
      tx_data:  o_serial = shreg[0];
      default:  o_serial = 1'b1;            // Idle and stop bit.
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= tx_idle;
      cycle   <= '0;
      bit_idx <= '0;
    end else begin
      if (state != tx_idle) begin
        cycle <= bit_end ? cycle_max : cycle - 1'b1;
      end
      case (state)
        tx_idle: begin
          // Credits guarantee the slot is empty when valid arrives.
          if (i_req.valid) begin
            state <= tx_start;
            cycle <= cycle_max;
          end
        end
        tx_start: begin
          if (bit_end) begin
            state   <= tx_data;
            bit_idx <= '0;
          end
        end
        tx_data: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= tx_stop;  // Eighth bit done.
          end
        end
        default: begin
          if (bit_end) state <= tx_idle;    // Stop bit over, credit goes back now.
        end
      endcase
    end
  end

  // Load on accept, shift at the end of each data bit.
  always_ff @(posedge clk) begin
    if (state == tx_idle && i_req.valid) begin
      shreg <= i_req.data;
    end else if (state == tx_data && bit_end) begin
      shreg <= shreg >> 1;
    end
  end

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
  parameter int cycles_per_bit = 4            // Clocks per bit, 2 or more.
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_serial,      // Looped-back line.
  output uart_pkg::uart_byte_t o_data,
  output logic                 o_valid,       // High for one bit time per byte.
  output uart_pkg::uart_sum_t  o_sum
);
  import uart_pkg::*;

  localparam int cycle_bits = $clog2(cycles_per_bit);
  localparam logic [cycle_bits-1:0] cycle_max = cycle_bits'(cycles_per_bit - 1);
  localparam logic [3:0] cursor_max = 4'd9;   // Nine shifts per frame.

  logic [cycle_bits-1:0] cycle;               // Countdown to the next shift.
  logic [3:0]            cursor;              // Shifts left, zero when idle.
  uart_byte_t            buffer;
  uart_byte_t            shifted;             // Buffer after taking this sample.
  uart_sum_t             sum;
  logic                  step;                // A shift happens this cycle.

  // New sample enters at the top, so the first bit ends up at bit 0.
  assign shifted = {i_serial, buffer[7:1]};
  assign step    = (cycle == '0) && (cursor != '0);

  assign o_data  = buffer;
  assign o_valid = cursor == 4'd1;            // Byte complete, stop bit pending.
  assign o_sum   = sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle  <= '0;
      cursor <= '0;
      sum    <= '0;
    end else if (cycle != '0) begin
      cycle <= cycle - 1'b1;
    end else if (cursor != '0) begin
      cycle  <= cycle_max;
      cursor <= cursor - 1'b1;
      // Last data bit lands, sum rises together with o_valid.
      if (cursor == 4'd2) sum <= sum + uart_sum_t'(shifted);
    end else if (!i_serial) begin
      cycle  <= cycle_max;                    // Start bit seen.
      cursor <= cursor_max;
    end
  end

  always_ff @(posedge clk) begin
    if (step) buffer <= shifted;
  end

endmodule

// ==== design/uart_hello.sv ====
`timescale 1ns/1ps

module uart_hello (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_start,    // Ignored while busy.
  input  logic              i_credit,   // One slot freed in the transmitter.
  output uart_pkg::tx_req_t o_req,
  output logic              o_busy,
  output logic              o_done      // Pulse on the last byte's credit.
);
  import uart_pkg::*;

  localparam int credit_bits = $clog2(tx_credits + 1);
  localparam logic [credit_bits-1:0] credit_full = credit_bits'(tx_credits);
  localparam msg_idx_t idx_last = msg_idx_t'(msg_len - 1);

  hello_state_t           state;
  logic [credit_bits-1:0] credits;      // Free slots in the transmitter.
  msg_idx_t               idx;          // Next byte to hand over.
  logic                   spend;        // Byte goes out this cycle.

  assign spend = (state == hello_send) && (credits != '0);

  // Byte 0 sits in the top byte of the packed text.
  assign o_req.valid = spend;
  assign o_req.data  = msg_text[8*(msg_len-1-int'(idx)) +: 8];

  assign o_busy = state != hello_idle;

  // Only one credit outstanding, and it is coming back now.
  assign o_done = (state == hello_drain) && i_credit &&
                  (credits == credit_full - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= hello_idle;
      credits <= credit_full;
      idx     <= '0;
    end else begin
      // Return and spend in one cycle cancel out.
      credits <= credits + credit_bits'(i_credit) - credit_bits'(spend);
      case (state)
        hello_idle: begin
          if (i_start) begin
            state <= hello_send;
            idx   <= '0;
          end
        end
        hello_send: begin
          if (spend) begin
            idx <= idx + 1'b1;
            if (idx == idx_last) state <= hello_drain;  // Last byte handed over.
          end
        end
        hello_drain: begin
          if (o_done) state <= hello_idle;
        end
        default: begin
          state <= hello_idle;
        end
      endcase
    end
  end

endmodule

// ==== design/uart_top.sv ====
`timescale 1ns/1ps

module uart_top #(
  parameter int cycles_per_bit = 4         // Passed to both ends of the line.
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_start,    // Send the message once.
  output logic                 o_serial,   // Copy of the loopback line.
  output uart_pkg::uart_byte_t o_data,
  output logic                 o_valid,
  output uart_pkg::uart_sum_t  o_sum,
  output logic                 o_busy,
  output logic                 o_done
);
  import uart_pkg::*;

  tx_req_t req;                            // Sender to transmitter.
  logic    credit;                         // Transmitter back to sender.
  logic    line;                           // Serial loopback.

  assign o_serial = line;

  uart_hello hello0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_start  (i_start),
    .i_credit (credit),
    .o_req    (req),
    .o_busy   (o_busy),
    .o_done   (o_done)
  );

  uart_tx #(.cycles_per_bit(cycles_per_bit)) tx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_req    (req),
    .o_credit (credit),
    .o_serial (line)
  );

  // Receiver listens on the transmitter's own line.
  uart_rx #(.cycles_per_bit(cycles_per_bit)) rx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_serial (line),
    .o_data   (o_data),
    .o_valid  (o_valid),
    .o_sum    (o_sum)
  );

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int half_period  = 5,   // 10 ns clock.
  parameter int reset_cycles = 4
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(half_period) o_clk = ~o_clk;
  end

  // Release lands just after an edge, like all other inputs.
  initial begin
    o_rst_n = 1'b0;
    repeat (reset_cycles) @(posedge o_clk);
    #1 o_rst_n = 1'b1;
  end

endmodule

// ==== tb/uart_asserts.sv ====
`timescale 1ns/1ps

module uart_asserts #(
  parameter int cycles_per_bit = 4
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 i_start,
  input logic                 i_serial,
  input uart_pkg::uart_byte_t i_data,
  input logic                 i_valid,
  input uart_pkg::uart_sum_t  i_sum,
  input logic                 i_busy,
  input logic                 i_done,
  input uart_pkg::tx_req_t    i_req,     // Sender to transmitter.
  input logic                 i_credit   // Transmitter back to sender.
);
  import uart_pkg::*;

  localparam int frame_len = 10 * cycles_per_bit;

  // Byte k of the text, first character in the top byte of the literal.
  function automatic uart_byte_t msg_byte(input int k);
    return uart_byte_t'(msg_text >> (8 * (msg_len - 1 - k)));
  endfunction

  function automatic uart_sum_t text_sum();
    uart_sum_t total;
    total = '0;
    for (int k = 0; k < msg_len; k++) total += uart_sum_t'(msg_byte(k));
    return total;
  endfunction

  localparam uart_sum_t msg_sum = text_sum();

  int unsigned fail_count = 0;  // Failed checks so far.
  logic        started;         // First start pulse seen.
  logic        valid_q;
  logic        rise;            // New byte from the receiver.
  uart_sum_t   sum_q;           // Sum one cycle ago.
  msg_idx_t    rx_idx;          // Expected text position of the next byte.
  int          rx_total;
  int          start_cnt;       // Starts taken while idle.
  int          done_cnt;
  int          outstanding;     // Requests not yet paid back by a credit.
  int          pos;             // Cycle within the current frame, 0 when idle.

  assign rise = i_valid && !valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started     <= 1'b0;
      valid_q     <= 1'b0;
      sum_q       <= '0;
      rx_idx      <= '0;
      rx_total    <= 0;
      start_cnt   <= 0;
      done_cnt    <= 0;
      outstanding <= 0;
      pos         <= 0;
    end else begin
      valid_q     <= i_valid;
      sum_q       <= i_sum;
      outstanding <= outstanding + int'(i_req.valid) - int'(i_credit);
      if (i_start) started <= 1'b1;
      if (i_start && !i_busy) start_cnt <= start_cnt + 1;
      if (i_done) done_cnt <= done_cnt + 1;
      if (rise) begin
        rx_total <= rx_total + 1;
        rx_idx   <= (rx_idx == msg_idx_t'(msg_len - 1)) ? '0 : rx_idx + 1'b1;
      end
      if (pos != 0) pos <= (pos == frame_len - 1) ? 0 : pos + 1;
      else if (!i_serial) pos <= 1;  // Falling edge of an idle line.
    end
  end

  // Covers reset as well, started is cleared there.
  idle_a: assert property (@(posedge clk)
    !started |-> (i_serial && !i_valid && !i_busy && !i_done))
    else begin fail_count++; $error("[ERROR] %0t: not idle before first start", $time); end

  start_bit_a: assert property (@(posedge clk) disable iff (!rst_n)
    (pos != 0 && pos < cycles_per_bit) |-> !i_serial)
    else begin fail_count++; $error("[ERROR] %0t: start bit too short", $time); end

  stop_bit_a: assert property (@(posedge clk) disable iff (!rst_n)
    (pos >= 9 * cycles_per_bit) |-> i_serial)
    else begin fail_count++; $error("[ERROR] %0t: stop bit not high", $time); end

  data_a: assert property (@(posedge clk) disable iff (!rst_n)
    rise |-> i_data == msg_byte(int'(rx_idx)))
    else begin fail_count++; $error("[ERROR] %0t: wrong byte %h", $time, i_data); end

  sum_a: assert property (@(posedge clk) disable iff (!rst_n)
    rise |-> i_sum == sum_q + uart_sum_t'(i_data))
    else begin fail_count++; $error("[ERROR] %0t: sum %h off", $time, i_sum); end

  done_sum_a: assert property (@(posedge clk) disable iff (!rst_n)
    i_done |-> i_sum == msg_sum * uart_sum_t'(done_cnt + 1))
    else begin fail_count++; $error("[ERROR] %0t: message sum %h off", $time, i_sum); end

  done_a: assert property (@(posedge clk) disable iff (!rst_n)
    i_done |-> (done_cnt < start_cnt) && (rx_total == msg_len * (done_cnt + 1)))
    else begin fail_count++; $error("[ERROR] %0t: done without full message", $time); end

  done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) i_done |=> !i_done)
    else begin fail_count++; $error("[ERROR] %0t: done longer than a cycle", $time); end

  start_a: assert property (@(posedge clk) disable iff (!rst_n)
    (i_start && !i_busy) |-> done_cnt == start_cnt)
    else begin fail_count++; $error("[ERROR] %0t: start before previous done", $time); end

  credit_a: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding >= 0 && outstanding <= tx_credits && (i_credit -> outstanding > 0))
    else begin fail_count++; $error("[ERROR] %0t: credits out of range", $time); end

endmodule

bind uart_top uart_asserts #(.cycles_per_bit(cycles_per_bit)) asserts0 (
  .clk      (clk),
  .rst_n    (rst_n),
  .i_start  (i_start),
  .i_serial (o_serial),
  .i_data   (o_data),
  .i_valid  (o_valid),
  .i_sum    (o_sum),
  .i_busy   (o_busy),
  .i_done   (o_done),
  .i_req    (req),
  .i_credit (credit)
);

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
  import uart_pkg::*;

  localparam int cycles_per_bit = 4;
  localparam int done_timeout   = msg_len * 12 * cycles_per_bit;  // Per message.
  localparam int reset_timeout  = 20;
  localparam int busy_timeout   = 10;
  localparam int messages       = 2;

  logic       clk;
  logic       rst_n;
  logic       i_start;
  logic       o_serial;
  uart_byte_t o_data;
  logic       o_valid;
  uart_sum_t  o_sum;
  logic       o_busy;
  logic       o_done;

  int timeouts = 0;  // Waits that ran out.
  int failures;      // Failed checks in the bound checker.

  tb_clock clock0 (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  uart_top #(.cycles_per_bit(cycles_per_bit)) dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_start  (i_start),
    .o_serial (o_serial),
    .o_data   (o_data),
    .o_valid  (o_valid),
    .o_sum    (o_sum),
    .o_busy   (o_busy),
    .o_done   (o_done)
  );

  // One-cycle start, driven just after the edge.
  task automatic pulse_start();
    @(posedge clk);
    #1 i_start = 1'b1;
    @(posedge clk);
    #1 i_start = 1'b0;
  endtask

  task automatic idle_gap(input int cycles);
    repeat (cycles) @(posedge clk);
  endtask

  // Outputs are sampled on the falling edge, half a cycle from any change.
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (!rst_n && cycles < reset_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!rst_n) begin
      timeouts++;
      $display("Reset still low after %0d cycles", reset_timeout);
    end
  endtask

  task automatic wait_busy();
    int cycles;
    cycles = 0;
    while (!o_busy && cycles < busy_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!o_busy) begin
      timeouts++;
      $display("Sender did not become busy within %0d cycles", busy_timeout);
    end
  endtask

  task automatic wait_done();
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < done_timeout) begin
      @(negedge clk);
      seen = o_done;
      cycles++;
    end
    if (!seen) begin
      timeouts++;
      $display("No done pulse within %0d cycles", done_timeout);
    end
  endtask

  initial begin
    int gap;
    i_start = 1'b0;
    void'($urandom(3));
    wait_reset_release();
    for (int m = 0; m < messages; m++) begin
      gap = 5 + int'($urandom % 16);
      idle_gap(gap);
      pulse_start();
      if (m == 0) begin
        wait_busy();
        idle_gap(gap);  // Second pulse lands mid-message and must be ignored.
        pulse_start();
      end
      wait_done();
    end
    idle_gap(2 * cycles_per_bit);
    failures = int'(dut0.asserts0.fail_count);
    $display("Timeouts: %0d, failed checks: %0d", timeouts, failures);
    if (timeouts == 0 && failures == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== src.f ====
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_hello.sv
design/uart_top.sv
tb/tb_clock.sv
tb/uart_asserts.sv
tb/tb_top.sv

// ==== Makefile ====
# Verilator build and run for the UART loopback testbench.

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
